/* eth_mii_pkg.sv */
`default_nettype none

// Constants seen on the MII receive pins and used by the FCS logic
package eth_mii_pkg;

   // Nibble repeated on RX_DATA during the preamble
   localparam logic [3:0] preamble_nibble = 4'h5;

   // Second nibble of the start-of-frame delimiter 0xD5
   localparam logic [3:0] sfd_nibble = 4'hD;

   // CRC-32 polynomial, bit reversed for LSB-first shifting
   localparam logic [31:0] crc_poly = 32'hEDB8_8320;

   // Register content after data plus a correct FCS has been folded in.
   // No final inversion is applied before the compare.
   localparam logic [31:0] crc_residue = 32'hDEBB_20E3;

endpackage

`default_nettype wire

/* eth_rx_pkg.sv */
`default_nettype none

// Frame-level limits and the per-frame status word
package eth_rx_pkg;

   localparam int len_w = 11;

   // Byte counts after the delimiter, FCS included
   localparam logic [len_w-1:0] min_frame_bytes = 11'd64;
   localparam logic [len_w-1:0] max_frame_bytes = 11'd1518;

   typedef enum logic [1:0] {
      err_crc      = 2'd0,
      err_short    = 2'd1,
      err_long     = 2'd2,
      err_overflow = 2'd3
   } err_code_t;

   // Accepted frame
   typedef struct packed {
      logic             ok;
      logic             bcast;
      logic [2:0]       rsvd;
      logic [len_w-1:0] len;
   } rx_stat_ok_t;

   // Rejected frame
   typedef struct packed {
      logic             ok;
      err_code_t        code;
      logic [1:0]       rsvd;
      logic [len_w-1:0] count;
   } rx_stat_err_t;

   // Top bit tells which view applies
   typedef union packed {
      rx_stat_ok_t  ok_v;
      rx_stat_err_t err_v;
   } rx_status_t;

endpackage

`default_nettype wire

/* eth_rx_byte_cnt.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_rx_byte_cnt import eth_rx_pkg::*; (
   input  wire              RX_CLK,
   input  wire              ETH_PHY_RESETN,
   input  wire              cnt_clear,
   input  wire              nib_valid,
   output logic             nibble_odd,
   output logic [len_w-1:0] count,
   output logic             too_long,
   output logic             short_frame
);

   // Count is complete bytes only, so it is valid once the frame has ended
   assign short_frame = count < min_frame_bytes;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         nibble_odd <= 1'b0;
         count      <= '0;
         too_long   <= 1'b0;
      end else if (cnt_clear) begin
         nibble_odd <= 1'b0;
         count      <= '0;
         too_long   <= 1'b0;
      end else if (nib_valid) begin
         nibble_odd <= !nibble_odd;
         // Byte completes on the high nibble
         if (nibble_odd) begin
            if (count == max_frame_bytes)
               too_long <= 1'b1;
            else
               count <= count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* eth_rx_crc.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_rx_crc import eth_mii_pkg::*; (
   input  wire       RX_CLK,
   input  wire       ETH_PHY_RESETN,
   input  wire       cnt_clear,
   input  wire       byte_valid,
   input  wire [7:0] byte_data,
   output logic      crc_ok
);

   logic [31:0] crc_q;

   // Eight LSB-first shift steps of the reflected CRC-32
   function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         if (r[0] ^ d[i])
            r = (r >> 1) ^ crc_poly;
         else
            r = r >> 1;
      end
      return r;
   endfunction

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN)
         crc_q <= '1;
      else if (cnt_clear)
         crc_q <= '1;
      else if (byte_valid)
         crc_q <= crc_byte(crc_q, byte_data);
   end

   // FCS bytes are folded in like data
   assign crc_ok = crc_q == crc_residue;

endmodule

`default_nettype wire

/* eth_rx_buf.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_rx_buf #(
   parameter int buf_depth_log2 = 11
) (
   input  wire        RX_CLK,
   input  wire        ETH_PHY_RESETN,
   input  wire        buf_wr,
   input  wire  [7:0] byte_data,
   input  wire        buf_commit,
   input  wire        buf_rewind,
   input  wire        out_credit,
   output logic       buf_full,
   output logic       out_valid,
   output logic [7:0] out_data,
   output logic       out_last
);

   localparam int aw     = buf_depth_log2;
   localparam int depth  = 1 << aw;
   // Queue of frame end positions
   localparam int eq_aw  = 3;
   localparam int cr_w   = 16;

   logic [7:0]  mem [depth];
   logic [aw:0] eq_mem [1 << eq_aw];

   // Pointers carry one wrap bit
   logic [aw:0]      wr_ptr;
   logic [aw:0]      cm_ptr;
   logic [aw:0]      rd_ptr;
   logic [eq_aw:0]   eq_wr;
   logic [eq_aw:0]   eq_rd;
   logic [cr_w-1:0]  credits;
   logic             mem_full;
   logic             eq_full;
   logic             wr_en;
   logic             send;

   assign mem_full = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
   assign eq_full  = (eq_wr[eq_aw] != eq_rd[eq_aw]) &&
                     (eq_wr[eq_aw-1:0] == eq_rd[eq_aw-1:0]);
   // A full end queue also stops the next frame
   assign buf_full = mem_full || eq_full;
   assign wr_en    = buf_wr && !buf_full && !buf_rewind;

   // Committed data and at least one credit
   assign send      = (rd_ptr != cm_ptr) && (credits != '0);
   assign out_valid = send;
   assign out_data  = mem[rd_ptr[aw-1:0]];
   assign out_last  = rd_ptr == eq_mem[eq_rd[eq_aw-1:0]];

   always_ff @(posedge RX_CLK) begin
      if (wr_en)
         mem[wr_ptr[aw-1:0]] <= byte_data;
      // Last byte of the frame being committed
      if (buf_commit && !eq_full)
         eq_mem[eq_wr[eq_aw-1:0]] <= wr_ptr - 1'b1;
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         wr_ptr  <= '0;
         cm_ptr  <= '0;
         rd_ptr  <= '0;
         eq_wr   <= '0;
         eq_rd   <= '0;
         credits <= '0;
      end else begin
         // Rewind drops everything since the last commit
         if (buf_rewind)
            wr_ptr <= cm_ptr;
         else if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;

         if (buf_commit && !eq_full) begin
            cm_ptr <= wr_ptr;
            eq_wr  <= eq_wr + 1'b1;
         end

         if (send) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (out_last)
               eq_rd <= eq_rd + 1'b1;
         end

         case ({out_credit, send})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

`default_nettype wire

/* eth_rx_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_rx_ctrl import eth_mii_pkg::*, eth_rx_pkg::*; #(
   parameter logic [47:0] mac_addr = 48'h02_00_00_00_00_01
) (
   input  wire              RX_CLK,
   input  wire              ETH_PHY_RESETN,
   input  wire  [3:0]       RX_DATA,
   input  wire              RX_DV,
   input  wire              nibble_odd,
   input  wire  [len_w-1:0] count,
   input  wire              too_long,
   input  wire              short_frame,
   input  wire              crc_ok,
   input  wire              buf_full,
   output logic             cnt_clear,
   output logic             nib_valid,
   output logic             byte_valid,
   output logic [7:0]       byte_data,
   output logic             buf_wr,
   output logic             buf_commit,
   output logic             buf_rewind,
   output logic             stat_valid,
   output rx_status_t       stat
);

   localparam logic [2:0] st_idle     = 3'd0;
   localparam logic [2:0] st_preamble = 3'd1;
   localparam logic [2:0] st_data     = 3'd2;
   localparam logic [2:0] st_drop     = 3'd3;
   localparam logic [2:0] st_report   = 3'd4;

   logic [2:0]  state;
   logic [3:0]  low_nib;
   logic [7:0]  cur_byte;
   logic [47:0] mac_sh;
   logic        byte_done;
   logic        addr_phase;
   logic        uc_match, bc_match;
   logic        uc_next, bc_next;
   logic        ovf;
   logic        frame_ok;
   err_code_t   err_sel;
   rx_status_t  stat_next;

   assign nib_valid = (state == st_data) && RX_DV;
   assign cnt_clear = (state == st_preamble) && RX_DV && (RX_DATA == sfd_nibble);
   // Second nibble of a byte is on the pins
   assign byte_done = nib_valid && nibble_odd;
   assign cur_byte  = {RX_DATA, low_nib};

   // Destination address compare, first octet is the MSB of mac_addr
   assign addr_phase = count < 11'd6;
   assign mac_sh     = mac_addr << (8 * count[2:0]);
   assign uc_next    = uc_match && (cur_byte == mac_sh[47:40]);
   assign bc_next    = bc_match && (cur_byte == 8'hFF);

   assign frame_ok = crc_ok && !short_frame && !too_long && !ovf;
   assign err_sel  = ovf ? err_overflow : too_long ? err_long :
                     short_frame ? err_short : err_crc;

   always_comb begin
      stat_next = '0;
      if (frame_ok) begin
         stat_next.ok_v.ok    = 1'b1;
         stat_next.ok_v.bcast = bc_match;
         stat_next.ok_v.len   = count;
      end else begin
         stat_next.err_v.ok    = 1'b0;
         stat_next.err_v.code  = err_sel;
         stat_next.err_v.count = count;
      end
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state      <= st_idle;
         byte_valid <= 1'b0;
         buf_wr     <= 1'b0;
         buf_commit <= 1'b0;
         buf_rewind <= 1'b0;
         stat_valid <= 1'b0;
         uc_match   <= 1'b0;
         bc_match   <= 1'b0;
         ovf        <= 1'b0;
      end else begin
         byte_valid <= 1'b0;
         buf_wr     <= 1'b0;
         buf_commit <= 1'b0;
         buf_rewind <= 1'b0;
         stat_valid <= 1'b0;
         // Buffer refused a write
         if (buf_wr && buf_full)
            ovf <= 1'b1;
         case (state)
            st_idle: begin
               if (RX_DV && RX_DATA == preamble_nibble)
                  state <= st_preamble;
            end
            st_preamble: begin
               if (!RX_DV) begin
                  state <= st_idle;
               end else if (cnt_clear) begin
                  state    <= st_data;
                  uc_match <= 1'b1;
                  bc_match <= 1'b1;
                  ovf      <= 1'b0;
               end else if (RX_DATA != preamble_nibble) begin
                  state <= st_drop;
               end
            end
            st_data: begin
               if (!RX_DV) begin
                  state <= st_report;
               end else if (byte_done) begin
                  byte_valid <= 1'b1;
                  buf_wr     <= !too_long;
                  if (addr_phase) begin
                     uc_match <= uc_next;
                     bc_match <= bc_next;
                  end
                  // Sixth byte decides, a miss is thrown away silently
                  if (count == 11'd5 && !uc_next && !bc_next) begin
                     state      <= st_drop;
                     buf_rewind <= 1'b1;
                  end
               end
            end
            st_drop: begin
               if (!RX_DV)
                  state <= st_idle;
            end
            st_report: begin
               stat_valid <= 1'b1;
               buf_commit <= frame_ok;
               buf_rewind <= !frame_ok;
               state      <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (nib_valid && !nibble_odd)
         low_nib <= RX_DATA;
      if (byte_done)
         byte_data <= cur_byte;
      if (state == st_report)
         stat <= stat_next;
   end

endmodule

`default_nettype wire

/* eth_rx_top.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_rx_top import eth_rx_pkg::*; #(
   parameter logic [47:0] mac_addr       = 48'h02_00_00_00_00_01,
   parameter int          buf_depth_log2 = 11
) (
   input  wire        RX_CLK,
   input  wire        ETH_PHY_RESETN,
   input  wire  [3:0] RX_DATA,
   input  wire        RX_DV,
   input  wire        out_credit,
   output logic       out_valid,
   output logic [7:0] out_data,
   output logic       out_last,
   output logic       stat_valid,
   output rx_status_t stat
);

   logic             cnt_clear;
   logic             nib_valid;
   logic             byte_valid;
   logic [7:0]       byte_data;
   logic             nibble_odd;
   logic [len_w-1:0] count;
   logic             too_long;
   logic             short_frame;
   logic             crc_ok;
   logic             buf_wr;
   logic             buf_commit;
   logic             buf_rewind;
   logic             buf_full;

   eth_rx_ctrl #(
      .mac_addr       (mac_addr)
   ) i_ctrl (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .RX_DATA        (RX_DATA),
      .RX_DV          (RX_DV),
      .nibble_odd     (nibble_odd),
      .count          (count),
      .too_long       (too_long),
      .short_frame    (short_frame),
      .crc_ok         (crc_ok),
      .buf_full       (buf_full),
      .cnt_clear      (cnt_clear),
      .nib_valid      (nib_valid),
      .byte_valid     (byte_valid),
      .byte_data      (byte_data),
      .buf_wr         (buf_wr),
      .buf_commit     (buf_commit),
      .buf_rewind     (buf_rewind),
      .stat_valid     (stat_valid),
      .stat           (stat)
   );

   eth_rx_byte_cnt i_byte_cnt (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .cnt_clear      (cnt_clear),
      .nib_valid      (nib_valid),
      .nibble_odd     (nibble_odd),
      .count          (count),
      .too_long       (too_long),
      .short_frame    (short_frame)
   );

   eth_rx_crc i_crc (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .cnt_clear      (cnt_clear),
      .byte_valid     (byte_valid),
      .byte_data      (byte_data),
      .crc_ok         (crc_ok)
   );

   // Store-and-forward buffer with the credit-controlled output
   eth_rx_buf #(
      .buf_depth_log2 (buf_depth_log2)
   ) i_buf (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .buf_wr         (buf_wr),
      .byte_data      (byte_data),
      .buf_commit     (buf_commit),
      .buf_rewind     (buf_rewind),
      .out_credit     (out_credit),
      .buf_full       (buf_full),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .out_last       (out_last)
   );

endmodule

`default_nettype wire

/* eth_rx_sva.sv */
`timescale 1ns/100ps
`default_nettype none

// Output credit rule and controller strobe rules
module eth_rx_sva (
   input wire RX_CLK,
   input wire ETH_PHY_RESETN,
   input wire out_valid,
   input wire out_credit,
   input wire stat_valid,
   input wire buf_commit,
   input wire buf_rewind
);

   // Credits granted and not yet used by the output
   logic [15:0] credit_model;
   int          fail_cnt = 0;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN)
         credit_model <= '0;
      else if (out_credit && !out_valid)
         credit_model <= credit_model + 1'b1;
      else if (out_valid && !out_credit)
         credit_model <= credit_model - 1'b1;
   end

   // A byte leaves only against a credit
   send_needs_credit: assert property (
      @(posedge RX_CLK) disable iff (!ETH_PHY_RESETN) out_valid |-> credit_model != '0)
      else begin
         fail_cnt++;
         $error("out_valid with zero credits");
      end

   stat_single_pulse: assert property (
      @(posedge RX_CLK) disable iff (!ETH_PHY_RESETN) stat_valid |=> !stat_valid)
      else begin
         fail_cnt++;
         $error("stat_valid high for more than one cycle");
      end

   commit_or_rewind: assert property (
      @(posedge RX_CLK) disable iff (!ETH_PHY_RESETN) !(buf_commit && buf_rewind))
      else begin
         fail_cnt++;
         $error("buf_commit and buf_rewind in the same cycle");
      end

endmodule

bind eth_rx_buf eth_rx_sva i_buf_sva (
   .RX_CLK         (RX_CLK),
   .ETH_PHY_RESETN (ETH_PHY_RESETN),
   .out_valid      (out_valid),
   .out_credit     (out_credit),
   .stat_valid     (1'b0),
   .buf_commit     (buf_commit),
   .buf_rewind     (buf_rewind)
);

bind eth_rx_ctrl eth_rx_sva i_ctrl_sva (
   .RX_CLK         (RX_CLK),
   .ETH_PHY_RESETN (ETH_PHY_RESETN),
   .out_valid      (1'b0),
   .out_credit     (1'b0),
   .stat_valid     (stat_valid),
   .buf_commit     (buf_commit),
   .buf_rewind     (buf_rewind)
);

`default_nettype wire

/* tb_eth_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_eth_rx import eth_rx_pkg::*; ();

   localparam logic [47:0] station       = 48'h02_00_00_00_00_01;
   localparam int          drain_limit   = 20000;
   localparam int          credit_window = 16;

   logic        RX_CLK         = 1'b0;
   logic        ETH_PHY_RESETN = 1'b0;
   logic [3:0]  RX_DATA        = 4'h0;
   logic        RX_DV          = 1'b0;
   logic        out_credit     = 1'b0;
   logic        out_valid;
   logic [7:0]  out_data;
   logic        out_last;
   logic        stat_valid;
   rx_status_t  stat;

   // Expected results queued by the driver when a frame ends
   rx_status_t  stat_q[$];
   logic [8:0]  byte_q[$];

   int   errors     = 0;
   int   credit_gap = 0;
   int   granted    = 0;
   int   received   = 0;
   int   neg_cyc    = 0;
   int   fall_cyc   = 0;
   int   tests_ok   = 0;
   int   tests_bad  = 0;
   logic dv_prev    = 1'b0;

   eth_rx_top #(
      .mac_addr       (station),
      .buf_depth_log2 (11)
   ) i_dut (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .RX_DATA        (RX_DATA),
      .RX_DV          (RX_DV),
      .out_credit     (out_credit),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .out_last       (out_last),
      .stat_valid     (stat_valid),
      .stat           (stat)
   );

   initial begin
      forever #5 RX_CLK = ~RX_CLK;
   end

   task automatic check_status(input rx_status_t got, input rx_status_t exp);
      if (got !== exp) begin
         errors++;
         if (exp.ok_v.ok)
            $display("[FAIL] %0t status %h, expected ok, bcast %0b, len %0d",
                     $time, got, exp.ok_v.bcast, exp.ok_v.len);
         else
            $display("[FAIL] %0t status %h, expected error code %0d, count %0d",
                     $time, got, exp.err_v.code, exp.err_v.count);
      end
   endtask

   task automatic check_byte(input logic [7:0] got_data, input logic got_last,
                             input logic [7:0] exp_data, input logic exp_last);
      if (got_data !== exp_data || got_last !== exp_last) begin
         errors++;
         $display("[FAIL] %0t output byte %h last %b, expected %h last %b",
                  $time, got_data, got_last, exp_data, exp_last);
      end
   endtask

   // Payload pattern mixing every index bit
   function automatic logic [7:0] fill_byte(input int i, input logic [7:0] seed);
      return seed ^ i[7:0] ^ {5'b0, i[10:8]};
   endfunction

   // Non-reflected CRC-32 taking bits in line order
   function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
      logic [31:0] n;
      logic        fb;
      n = c;
      for (int b = 0; b < 8; b++) begin
         fb = n[31] ^ d[b];
         n  = {n[30:0], 1'b0};
         if (fb)
            n = n ^ 32'h04C1_1DB7;
      end
      return n;
   endfunction

   task automatic drive_nibble(input logic [3:0] n);
      RX_DV   <= 1'b1;
      RX_DATA <= n;
      @(posedge RX_CLK);
   endtask

   task automatic send_frame(input logic [47:0] dst, input int flen, input logic [7:0] seed,
                             input int bad_fcs, input int stat_exp, input rx_status_t status,
                             input int bytes_exp);
      logic [7:0]  fr[$];
      logic [31:0] crc_n;
      logic [31:0] fcs;
      int          i;
      for (i = 0; i < flen - 4; i++)
         fr.push_back(i < 6 ? dst[47 - 8*i -: 8] : fill_byte(i, seed));
      crc_n = '1;
      foreach (fr[k])
         crc_n = crc_step(crc_n, fr[k]);
      // FCS is the inverted register in reflected bit order
      for (i = 0; i < 32; i++)
         fcs[i] = ~crc_n[31 - i];
      for (i = 0; i < 4; i++)
         fr.push_back(fcs[8*i +: 8]);
      if (bad_fcs != 0)
         fr[flen - 1] = fr[flen - 1] ^ 8'h5a;
      for (i = 0; i < 15; i++)
         drive_nibble(4'h5);
      drive_nibble(4'hD);
      foreach (fr[k]) begin
         drive_nibble(fr[k][3:0]);
         drive_nibble(fr[k][7:4]);
      end
      RX_DV   <= 1'b0;
      RX_DATA <= 4'h0;
      if (stat_exp != 0)
         stat_q.push_back(status);
      if (bytes_exp != 0)
         foreach (fr[k])
            byte_q.push_back({k == flen - 1, fr[k]});
      // Inter-frame gap
      repeat (24) @(posedge RX_CLK);
   endtask

   task automatic finish_test(input int num, input logic [8*24-1:0] name, input int err_mark);
      int t;
      for (t = 0; t < drain_limit && (stat_q.size() != 0 || byte_q.size() != 0); t++)
         @(posedge RX_CLK);
      if (stat_q.size() != 0 || byte_q.size() != 0) begin
         errors++;
         $display("Timed out waiting for %0d status words and %0d output bytes",
                  stat_q.size(), byte_q.size());
         stat_q.delete();
         byte_q.delete();
      end
      // Room for stray output after the last expected item
      repeat (20) @(posedge RX_CLK);
      if (errors == err_mark) begin
         tests_ok++;
         $display("test %0d %0s: ok", num, name);
      end else begin
         tests_bad++;
         $display("test %0d %0s: %0d errors", num, name, errors - err_mark);
      end
   endtask

   // Credit source keeping a bounded number of credits outstanding
   initial begin
      int gap_cnt;
      gap_cnt = 0;
      void'($urandom(32'h06cf_38db));
      forever begin
         @(posedge RX_CLK);
         if (!ETH_PHY_RESETN || granted - received >= credit_window) begin
            out_credit <= 1'b0;
         end else if (credit_gap == 0) begin
            out_credit <= 1'b1;
         end else if (gap_cnt == 0) begin
            out_credit <= 1'b1;
            gap_cnt = $urandom % credit_gap;
         end else begin
            out_credit <= 1'b0;
            gap_cnt--;
         end
      end
   end

   // Outputs are sampled mid-cycle
   always @(negedge RX_CLK) begin
      logic [8:0] exp_b;
      if (ETH_PHY_RESETN) begin
         neg_cyc++;
         if (dv_prev && !RX_DV)
            fall_cyc = neg_cyc;
         dv_prev = RX_DV;
         if (out_valid) begin
            received++;
            if (received > granted) begin
               errors++;
               $display("[FAIL] %0t byte %0d sent with %0d credits granted",
                        $time, received, granted);
            end
            if (byte_q.size() == 0) begin
               errors++;
               $display("Output byte %h arrived while no frame bytes were expected", out_data);
            end else begin
               exp_b = byte_q.pop_front();
               check_byte(out_data, out_last, exp_b[7:0], exp_b[8]);
            end
         end
         if (out_credit)
            granted++;
         if (stat_valid) begin
            if (neg_cyc - fall_cyc != 2) begin
               errors++;
               $display("[FAIL] %0t status came %0d cycles after RX_DV fell, expected 2",
                        $time, neg_cyc - fall_cyc);
            end
            if (stat_q.size() == 0) begin
               errors++;
               $display("Status word %h arrived for a frame that should give none", stat);
            end else begin
               check_status(stat, stat_q.pop_front());
            end
         end
      end
   end

   initial begin
      int               fd;
      string            line;
      int               t_num;
      logic [8*24-1:0]  t_name;
      int               err_mark;
      int               in_test;
      int               gap;
      logic [47:0]      dst;
      int               flen;
      logic [7:0]       seed;
      int               bad;
      int               sexp;
      logic [15:0]      st_word;
      int               bexp;
      in_test  = 0;
      err_mark = 0;
      t_num    = 0;
      t_name   = '0;
      fd = $fopen("eth_rx_trace.txt", "r");
      repeat (10) @(posedge RX_CLK);
      ETH_PHY_RESETN <= 1'b1;
      repeat (5) @(posedge RX_CLK);
      if (fd == 0) begin
         errors++;
         $display("Could not open the trace file eth_rx_trace.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
               continue;
            case (line.getc(0))
               "T": begin
                  if (in_test != 0)
                     finish_test(t_num, t_name, err_mark);
                  void'($sscanf(line, "T %d %s", t_num, t_name));
                  err_mark = errors;
                  in_test  = 1;
               end
               "C": begin
                  if ($sscanf(line, "C %d", gap) == 1)
                     credit_gap <= gap;
               end
               "F": begin
                  if ($sscanf(line, "F %h %d %h %d %d %h %d",
                              dst, flen, seed, bad, sexp, st_word, bexp) == 7) begin
                     send_frame(dst, flen, seed, bad, sexp, st_word, bexp);
                  end else begin
                     errors++;
                     $display("Trace line could not be read: %s", line);
                  end
               end
               default: ;
            endcase
         end
         if (in_test != 0)
            finish_test(t_num, t_name, err_mark);
         $fclose(fd);
      end
      errors += i_dut.i_buf.i_buf_sva.fail_cnt + i_dut.i_ctrl.i_ctrl_sva.fail_cnt;
      $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* eth_rx_trace.txt */
# T <test> <name> | C <max gap between credits, 0 = every cycle>
# F <dst mac> <bytes incl FCS> <fill seed> <bad FCS> <status due> <status hex> <bytes due>
T 1 good_unicast
C 0
F 020000000001 64 3c 0 1 8040 1
F 020000000001 100 a7 0 1 8064 1
T 2 broadcast
F ffffffffffff 72 11 0 1 c048 1
T 3 other_address
F 020000000002 64 5e 0 0 0000 0
F 0a0000000001 80 42 0 0 0000 0
T 4 bad_fcs
F 020000000001 64 77 1 1 0040 0
F 020000000001 68 78 0 1 8044 1
T 5 length_limits
F 020000000001 40 19 0 1 2028 0
F 020000000001 1530 c2 0 1 45ee 0
F 020000000001 1518 c3 0 1 85ee 1
T 6 sparse_credits
C 24
F 020000000001 64 01 0 1 8040 1
F ffffffffffff 90 02 0 1 c05a 1
F 020000000001 120 03 0 1 8078 1
F 020000000001 64 04 1 1 0040 0
F 020000000001 75 05 0 1 804b 1

/* filelist.f */
eth_mii_pkg.sv
eth_rx_pkg.sv
eth_rx_byte_cnt.sv
eth_rx_crc.sv
eth_rx_buf.sv
eth_rx_ctrl.sv
eth_rx_top.sv
eth_rx_sva.sv
tb_eth_rx.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eth_rx
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
